/* common/pcxt_clk_pkg.sv */
/*
 * Shared constants for the PC/XT clock-enable and reset controller.
 * Holds the CPU speed codes, the accumulator increments for each rate,
 * the audio sample rate and the counter widths.
 * Modules import it inside their body or use scoped names in headers.
 */

`default_nettype none

package pcxt_clk_pkg;

	//////////////////////////////
	// CPU speed select
	//////////////////////////////

	localparam int SPEED_W = 2;

	// Code 3 is unused and runs as 4.77
	localparam logic [SPEED_W-1:0] SPEED_4_77   = 2'd0;
	localparam logic [SPEED_W-1:0] SPEED_7_16   = 2'd1;
	localparam logic [SPEED_W-1:0] SPEED_14_318 = 2'd2;

	//////////////////////////////
	// Rate constants
	//////////////////////////////

	// Base clock, kHz, modulus of the CPU accumulator
	localparam int REF_KHZ = 50000;

	// CPU increments in kHz
	localparam int INC_4_77   = 4773;
	localparam int INC_7_16   = 7159;
	localparam int INC_14_318 = 14318;

	// Audio sample rate against the base clock in Hz
	localparam int AUDIO_HZ = 44100;
	localparam int REF_HZ   = 50000000;

	//////////////////////////////
	// Widths
	//////////////////////////////

	localparam int ACC_W = 32;
	// Reset, splash and delay counters
	localparam int CNT_W = 32;

endpackage

`default_nettype wire

/* clocking/frac_cen.sv */
/*
 * Fractional clock-enable generator.
 * Adds inc to an accumulator on every clock; when the sum reaches MODULUS
 * it wraps and emits a one-cycle enable, so the average enable rate is
 * inc/MODULUS of the clock. inc must stay below MODULUS.
 */

`timescale 1ns/1ps
`default_nettype none

module frac_cen #(
	parameter int ACC_W   = pcxt_clk_pkg::ACC_W,
	parameter int MODULUS = pcxt_clk_pkg::REF_HZ
) (
	input  wire              CLK_50M,
	input  wire              reset_wire,
	input  wire  [ACC_W-1:0] inc,
	output logic             cen
);

	// One guard bit so the sum cannot overflow
	localparam logic [ACC_W:0] MOD_EXT = (ACC_W+1)'(MODULUS);

	logic [ACC_W-1:0] acc;
	logic [ACC_W:0]   acc_sum;
	logic [ACC_W:0]   acc_wrap;

	assign acc_sum  = {1'b0, acc} + {1'b0, inc};
	assign acc_wrap = acc_sum - MOD_EXT;

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			acc <= '0;
			cen <= 1'b0;
		end else if (acc_sum >= MOD_EXT) begin
			// Wrap and keep the remainder
			acc <= acc_wrap[ACC_W-1:0];
			cen <= 1'b1;
		end else begin
			acc <= acc_sum[ACC_W-1:0];
			cen <= 1'b0;
		end
	end

	// Increment from the driving block must stay below the modulus,
	// otherwise one wrap would swallow a second enable
	a_inc_below_mod: assert property (
		@(posedge CLK_50M) disable iff (reset_wire)
		{1'b0, inc} < MOD_EXT
	) else $error("frac_cen increment %0d not below modulus %0d", inc, MODULUS);

endmodule

`default_nettype wire

/* clocking/cpu_clock_ctrl.sv */
/*
 * CPU clock-enable control.
 * Latches the requested speed only when bus_done marks the end of a bus
 * cycle, reports turbo for the fast rates and drives a fractional
 * enable generator with the increment of the latched speed.
 */

`timescale 1ns/1ps
`default_nettype none

module cpu_clock_ctrl #(
	parameter int ACC_W = pcxt_clk_pkg::ACC_W
) (
	input  wire                                CLK_50M,
	input  wire                                reset_wire,
	input  wire  [pcxt_clk_pkg::SPEED_W-1:0]   speed_sel,
	input  wire                                bus_done,
	output logic                               turbo_mode,
	output logic                               cpu_cen
);

	import pcxt_clk_pkg::*;

	logic [SPEED_W-1:0] speed_q;
	logic [ACC_W-1:0]   cpu_inc;

	//////////////////////////////
	// Speed latch
	//////////////////////////////

	// Only at a bus-cycle boundary, so no transfer sees a rate change
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			speed_q    <= SPEED_4_77;
			turbo_mode <= 1'b0;
		end else if (bus_done) begin
			speed_q    <= speed_sel;
			// Turbo flag registered alongside the code
			turbo_mode <= (speed_sel == SPEED_7_16) || (speed_sel == SPEED_14_318);
		end
	end

	// Unused code falls back to 4.77
	always_comb begin
		case (speed_q)
			SPEED_7_16:   cpu_inc = ACC_W'(INC_7_16);
			SPEED_14_318: cpu_inc = ACC_W'(INC_14_318);
			default:      cpu_inc = ACC_W'(INC_4_77);
		endcase
	end

	//////////////////////////////
	// Enable generator
	//////////////////////////////

	frac_cen #(
		.ACC_W   (ACC_W),
		.MODULUS (REF_KHZ)
	) u_cpu_cen (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.inc        (cpu_inc),
		.cen        (cpu_cen)
	);

	// Turbo flag agrees with the rate fed to the enable generator
	a_turbo_matches_rate: assert property (
		@(posedge CLK_50M) disable iff (reset_wire)
		turbo_mode == (cpu_inc != ACC_W'(INC_4_77))
	) else $error("turbo_mode disagrees with CPU increment %0d", cpu_inc);

endmodule

`default_nettype wire

/* reset/sys_reset_stretch.sv */
/*
 * Power-on reset stretcher.
 * Keeps sys_reset high while reset_wire is high and for a fixed number
 * of clocks after its release, to let the rest of the system settle.
 * sys_reset falls on edge RESET_HOLD_CYCLES+1 after the release.
 */

`timescale 1ns/1ps
`default_nettype none

module sys_reset_stretch #(
	parameter int RESET_HOLD_CYCLES = 65535
) (
	input  wire  CLK_50M,
	input  wire  reset_wire,
	output logic sys_reset
);

	import pcxt_clk_pkg::*;

	localparam logic [CNT_W-1:0] HOLD_CNT = CNT_W'(RESET_HOLD_CYCLES);

	logic [CNT_W-1:0] hold_cnt;

	// Saturating count, stops at the hold value
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			sys_reset <= 1'b1;
			hold_cnt  <= '0;
		end else if (sys_reset) begin
			if (hold_cnt != HOLD_CNT) begin
				hold_cnt <= hold_cnt + 1'b1;
			end else begin
				// Hold time over
				sys_reset <= 1'b0;
			end
		end
	end

	// Once released, stays released until the next reset_wire
	a_no_reassert: assert property (
		@(posedge CLK_50M) disable iff (reset_wire)
		!sys_reset |=> !sys_reset
	) else $error("sys_reset rose again without reset_wire");

endmodule

`default_nettype wire

/* reset/splash_timer.sv */
/*
 * Splash-screen hold timer.
 * splash_active comes up with reset and drops after SPLASH_SECONDS
 * seconds of TICKS_PER_SECOND clocks, or one clock after splash_skip
 * is seen. It stays low until the next reset_wire.
 */

`timescale 1ns/1ps
`default_nettype none

module splash_timer #(
	parameter int TICKS_PER_SECOND = 50000000,
	parameter int SPLASH_SECONDS   = 5
) (
	input  wire  CLK_50M,
	input  wire  reset_wire,
	input  wire  splash_skip,
	output logic splash_active
);

	import pcxt_clk_pkg::*;

	// Last tick of a second and last second of the hold
	localparam logic [CNT_W-1:0] TICK_LAST = CNT_W'(TICKS_PER_SECOND - 1);
	localparam logic [CNT_W-1:0] SEC_LAST  = CNT_W'(SPLASH_SECONDS - 1);

	logic [CNT_W-1:0] tick_cnt;
	logic [CNT_W-1:0] sec_cnt;

	//////////////////////////////
	// Tick and seconds counters
	//////////////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			splash_active <= 1'b1;
			tick_cnt      <= '0;
			sec_cnt       <= '0;
		end else if (splash_active) begin
			if (splash_skip) begin
				// User skipped the screen
				splash_active <= 1'b0;
			end else if (tick_cnt == TICK_LAST) begin
				tick_cnt <= '0;
				if (sec_cnt == SEC_LAST) begin
					// Full hold time reached
					splash_active <= 1'b0;
				end else begin
					sec_cnt <= sec_cnt + 1'b1;
				end
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

	// Only reset_wire may bring the splash back
	a_no_splash_rise: assert property (
		@(posedge CLK_50M) disable iff (reset_wire)
		!$rose(splash_active)
	) else $error("splash_active rose without reset_wire");

endmodule

`default_nettype wire

/* reset/cpu_reset_seq.sv */
/*
 * CPU reset sequencer.
 * Synchronizes the system reset, merges it with the splash hold and
 * releases cpu_reset CPU_RESET_DELAY clocks after both are gone.
 * The machine model is sampled while sys_reset is high and held after,
 * so it only changes across a reset.
 */

`timescale 1ns/1ps
`default_nettype none

module cpu_reset_seq #(
	parameter int CPU_RESET_DELAY = 42
) (
	input  wire  CLK_50M,
	input  wire  reset_wire,
	input  wire  sys_reset,
	input  wire  splash_active,
	input  wire  model_sel,
	output logic cpu_reset,
	output logic tandy_mode
);

	import pcxt_clk_pkg::*;

	localparam logic [CNT_W-1:0] DELAY_CNT = CNT_W'(CPU_RESET_DELAY);

	logic             sys_sync1;
	logic             sys_sync2;
	logic             hold;
	logic [CNT_W-1:0] delay_cnt;

	//////////////////////////////
	// System reset synchronizer
	//////////////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			sys_sync1 <= 1'b1;
			sys_sync2 <= 1'b1;
		end else begin
			sys_sync1 <= sys_reset;
			sys_sync2 <= sys_sync1;
		end
	end

	// Stage one also holds, so cpu_reset is up before stage two rises
	assign hold = sys_sync1 | sys_sync2 | splash_active;

	//////////////////////////////
	// Release delay
	//////////////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			cpu_reset <= 1'b1;
			delay_cnt <= '0;
		end else if (hold) begin
			// Any hold restarts the delay
			cpu_reset <= 1'b1;
			delay_cnt <= '0;
		end else if (delay_cnt != DELAY_CNT) begin
			delay_cnt <= delay_cnt + 1'b1;
		end else begin
			cpu_reset <= 1'b0;
		end
	end

	// Model latch, open while sys_reset is high
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			tandy_mode <= 1'b0;
		end else if (sys_reset) begin
			tandy_mode <= model_sel;
		end
	end

	// CPU never runs while the synchronized system reset is up
	a_cpu_in_reset: assert property (
		@(posedge CLK_50M) disable iff (reset_wire)
		sys_sync2 |-> cpu_reset
	) else $error("cpu_reset low while system reset held");

endmodule

`default_nettype wire

/* design/pcxt_clock_reset.sv */
/*
 * Clock-enable and reset controller of the PC/XT core.
 * Ties together the reset stretcher, splash timer, CPU reset sequencer,
 * the CPU enable with its speed latch and the 44.1 kHz audio enable.
 * All logic runs on CLK_50M; rates come out as one-cycle enables.
 */

`timescale 1ns/1ps
`default_nettype none

module pcxt_clock_reset #(
	parameter int RESET_HOLD_CYCLES = 65535,
	parameter int TICKS_PER_SECOND  = 50000000,
	parameter int SPLASH_SECONDS    = 5,
	parameter int CPU_RESET_DELAY   = 42
) (
	input  wire                                CLK_50M,
	input  wire                                reset_wire,
	input  wire  [pcxt_clk_pkg::SPEED_W-1:0]   speed_sel,
	input  wire                                bus_done,
	input  wire                                model_sel,
	input  wire                                splash_skip,
	output logic                               sys_reset,
	output logic                               splash_active,
	output logic                               cpu_reset,
	output logic                               tandy_mode,
	output logic                               turbo_mode,
	output logic                               cpu_cen,
	output logic                               audio_cen
);

	import pcxt_clk_pkg::*;

	localparam logic [ACC_W-1:0] AUDIO_INC = ACC_W'(AUDIO_HZ);

	//////////////////////////////
	// Reset path
	//////////////////////////////

	sys_reset_stretch #(
		.RESET_HOLD_CYCLES (RESET_HOLD_CYCLES)
	) u_sys_reset_stretch (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.sys_reset  (sys_reset)
	);

	splash_timer #(
		.TICKS_PER_SECOND (TICKS_PER_SECOND),
		.SPLASH_SECONDS   (SPLASH_SECONDS)
	) u_splash_timer (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.splash_skip   (splash_skip),
		.splash_active (splash_active)
	);

	// CPU held by both of the above
	cpu_reset_seq #(
		.CPU_RESET_DELAY (CPU_RESET_DELAY)
	) u_cpu_reset_seq (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.sys_reset     (sys_reset),
		.splash_active (splash_active),
		.model_sel     (model_sel),
		.cpu_reset     (cpu_reset),
		.tandy_mode    (tandy_mode)
	);

	//////////////////////////////
	// Clock enables
	//////////////////////////////

	cpu_clock_ctrl #(
		.ACC_W (ACC_W)
	) u_cpu_clock_ctrl (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.speed_sel  (speed_sel),
		.bus_done   (bus_done),
		.turbo_mode (turbo_mode),
		.cpu_cen    (cpu_cen)
	);

	// Audio sample strobe, 44.1 kHz out of 50 MHz
	frac_cen #(
		.ACC_W   (ACC_W),
		.MODULUS (REF_HZ)
	) u_audio_cen (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.inc        (AUDIO_INC),
		.cen        (audio_cen)
	);

endmodule

`default_nettype wire

/* verif/tb_pcxt_clock_reset.sv */
/*
 * Self-checking testbench for the PC/XT clock-enable and reset controller.
 * Drives random speed, bus-done and model inputs from an LFSR and checks
 * every output against a cycle model kept in the testbench.
 * Two runs: a plain splash timeout, then a reset pulse with an early skip.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_pcxt_clock_reset;

	// Small values so the reset path finishes quickly
	localparam int HOLD          = 20;
	localparam int TPS           = 50;
	localparam int SECS          = 3;
	localparam int CPU_DELAY     = 42;
	localparam int SPLASH_CYCLES = TPS * SECS;

	// Reference rates for the model
	localparam int CPU_MOD   = 50000;
	localparam int AUDIO_INC = 44100;
	localparam int AUDIO_MOD = 50000000;

	logic       CLK_50M;
	logic       reset_wire;
	logic [1:0] speed_sel;
	logic       bus_done;
	logic       model_sel;
	logic       splash_skip;
	logic       sys_reset;
	logic       splash_active;
	logic       cpu_reset;
	logic       tandy_mode;
	logic       turbo_mode;
	logic       cpu_cen;
	logic       audio_cen;

	logic [15:0] lfsr_state;
	int          error_count;
	int          skip_at;

	// Edges at which the DUT outputs were first seen low
	int          dut_sys_fall;
	int          dut_splash_fall;

	// Model state
	int         rel_edges;
	int         sys_fall_edge;
	int         splash_fall_edge;
	logic       m_sys_reset;
	logic       m_splash;
	logic       m_tandy;
	logic [1:0] m_speed;
	logic       m_turbo;
	logic       m_cpu_cen;
	logic       m_audio_cen;
	int         m_cpu_acc;
	int         m_audio_acc;

	pcxt_clock_reset #(
		.RESET_HOLD_CYCLES (HOLD),
		.TICKS_PER_SECOND  (TPS),
		.SPLASH_SECONDS    (SECS),
		.CPU_RESET_DELAY   (CPU_DELAY)
	) UUT (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.speed_sel     (speed_sel),
		.bus_done      (bus_done),
		.model_sel     (model_sel),
		.splash_skip   (splash_skip),
		.sys_reset     (sys_reset),
		.splash_active (splash_active),
		.cpu_reset     (cpu_reset),
		.tandy_mode    (tandy_mode),
		.turbo_mode    (turbo_mode),
		.cpu_cen       (cpu_cen),
		.audio_cen     (audio_cen)
	);

	// 50 MHz
	always #10 CLK_50M = ~CLK_50M;

	//////////////////////////////
	// Random source
	//////////////////////////////

	// Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 16'hB400;
		end
		return n;
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] random_bits(input int width);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < width; i++) begin
			v[i] = lfsr_state[0];
			lfsr_state = lfsr_step(lfsr_state);
		end
		return v;
	endfunction

	task automatic drive_random();
		speed_sel = random_bits(2);
		// Bus cycle ends about one clock in four
		bus_done  = (random_bits(2) == 0);
		model_sel = random_bits(1);
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic int speed_inc(input logic [1:0] code);
		case (code)
			2'd1:    return 7159;
			2'd2:    return 14318;
			default: return 4773;
		endcase
	endfunction

	task automatic model_reset();
		rel_edges        = 0;
		sys_fall_edge    = -1;
		splash_fall_edge = -1;
		m_sys_reset      = 1'b1;
		m_splash         = 1'b1;
		m_tandy          = 1'b0;
		m_speed          = 2'd0;
		m_turbo          = 1'b0;
		m_cpu_cen        = 1'b0;
		m_audio_cen      = 1'b0;
		m_cpu_acc        = 0;
		m_audio_acc      = 0;
	endtask

	// One rising edge with the inputs present at it
	task automatic model_step();
		int sum;
		if (reset_wire) begin
			model_reset();
		end else begin
			rel_edges++;
			// Model latch open while the old sys_reset is high
			if (m_sys_reset) begin
				m_tandy = model_sel;
			end
			if (m_sys_reset && rel_edges > HOLD) begin
				m_sys_reset   = 1'b0;
				sys_fall_edge = rel_edges;
			end
			if (m_splash && (splash_skip || rel_edges == SPLASH_CYCLES)) begin
				m_splash         = 1'b0;
				splash_fall_edge = rel_edges;
			end
			// CPU accumulator steps with the speed held before this edge
			sum       = m_cpu_acc + speed_inc(m_speed);
			m_cpu_cen = (sum >= CPU_MOD);
			m_cpu_acc = m_cpu_cen ? sum - CPU_MOD : sum;
			if (bus_done) begin
				m_speed = speed_sel;
				m_turbo = (speed_sel == 2'd1) || (speed_sel == 2'd2);
			end
			sum         = m_audio_acc + AUDIO_INC;
			m_audio_cen = (sum >= AUDIO_MOD);
			m_audio_acc = m_audio_cen ? sum - AUDIO_MOD : sum;
		end
	endtask

	//////////////////////////////
	// Checks
	//////////////////////////////

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			error_count++;
			$display("FAILED %s: expected 0x%0h, got 0x%0h at %0t ns",
				name, expected, actual, $time);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Timeout: %s", what);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_outputs();
		int later;
		int since;
		check_value("sys_reset", m_sys_reset, sys_reset);
		check_value("splash_active", m_splash, splash_active);
		check_value("tandy_mode", m_tandy, tandy_mode);
		check_value("turbo_mode", m_turbo, turbo_mode);
		check_value("cpu_cen", m_cpu_cen, cpu_cen);
		check_value("audio_cen", m_audio_cen, audio_cen);
		// cpu_reset only has a release window
		if (m_sys_reset || m_splash) begin
			check_value("cpu_reset", 1, cpu_reset);
		end else begin
			later = (sys_fall_edge > splash_fall_edge) ? sys_fall_edge : splash_fall_edge;
			since = rel_edges - later;
			if (since <= CPU_DELAY) begin
				check_value("cpu_reset", 1, cpu_reset);
			end else if (since >= CPU_DELAY + 4) begin
				check_value("cpu_reset", 0, cpu_reset);
			end
		end
	endtask

	task automatic note_dut_falls();
		if (reset_wire) begin
			dut_sys_fall    = -1;
			dut_splash_fall = -1;
		end else begin
			if (!sys_reset && dut_sys_fall < 0) begin
				dut_sys_fall = rel_edges;
			end
			if (!splash_active && dut_splash_fall < 0) begin
				dut_splash_fall = rel_edges;
			end
		end
	endtask

	// Sample 1 ns after the edge before new inputs go out
	task automatic cycle();
		@(posedge CLK_50M);
		#1;
		model_step();
		check_outputs();
		note_dut_falls();
	endtask

	//////////////////////////////
	// Sequences
	//////////////////////////////

	task automatic apply_reset();
		reset_wire  = 1'b1;
		splash_skip = 1'b0;
		model_reset();
		repeat (10) begin
			cycle();
			drive_random();
		end
		reset_wire = 1'b0;
	endtask

	task automatic run_random(input int cycles);
		repeat (cycles) begin
			cycle();
			drive_random();
		end
	endtask

	task automatic wait_splash_end(input int timeout);
		int n;
		n = 0;
		while (splash_active && n < timeout) begin
			cycle();
			drive_random();
			n++;
		end
		if (splash_active) begin
			abort_on_timeout("splash_active did not fall after the reset release");
		end
	endtask

	task automatic wait_cpu_release(input int timeout);
		int n;
		n = 0;
		while (cpu_reset && n < timeout) begin
			cycle();
			drive_random();
			n++;
		end
		if (cpu_reset) begin
			abort_on_timeout("cpu_reset was never released");
		end
	endtask

	initial begin
		CLK_50M         = 1'b0;
		reset_wire      = 1'b1;
		speed_sel       = 2'd0;
		bus_done        = 1'b0;
		model_sel       = 1'b0;
		splash_skip     = 1'b0;
		lfsr_state      = 16'd43471;
		error_count     = 0;
		skip_at         = 0;
		dut_sys_fall    = -1;
		dut_splash_fall = -1;
		model_reset();

		// Run 1 lets the splash run its full time
		apply_reset();
		wait_splash_end(SPLASH_CYCLES + 50);
		check_value("splash_active fall edge", SPLASH_CYCLES, dut_splash_fall);
		wait_cpu_release(200);
		check_value("sys_reset fall edge", HOLD + 1, dut_sys_fall);
		// Long random stretch for speed changes and audio strobes
		run_random(6000);

		// Run 2 skips at a random point after release
		apply_reset();
		skip_at = int'(random_bits(5)) + 1;
		repeat (skip_at - 1) begin
			cycle();
			drive_random();
		end
		splash_skip = 1'b1;
		cycle();
		splash_skip = 1'b0;
		drive_random();
		wait_splash_end(10);
		check_value("splash_active fall edge", skip_at, dut_splash_fall);
		wait_cpu_release(200);
		check_value("sys_reset fall edge", HOLD + 1, dut_sys_fall);
		run_random(2000);

		if (error_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
common/pcxt_clk_pkg.sv
clocking/frac_cen.sv
clocking/cpu_clock_ctrl.sv
reset/sys_reset_stretch.sv
reset/splash_timer.sv
reset/cpu_reset_seq.sv
design/pcxt_clock_reset.sv
verif/tb_pcxt_clock_reset.sv
